/* hdl/bwt_ext_pkg.sv */
// BWT extension shared types

package bwt_ext_pkg;

	// ----------------------------------------------------------------------
	// widths with a meaning
	// ----------------------------------------------------------------------

	// position or interval bound in the BWT
	typedef logic [63:0] bwt_idx_t;
	// occurrence count of one base
	typedef logic [31:0] occ_cnt_t;
	// 32 bases, 2 bits each
	typedef logic [63:0] bwt_word_t;
	// four 8-bit base counters, code c in byte c
	typedef logic [31:0] byte_cnt_t;

	// ----------------------------------------------------------------------
	// fixed pipeline values
	// ----------------------------------------------------------------------

	localparam int OCC_LATENCY = 7;
	localparam int EXT_STAGES  = 5;
	localparam int NUM_BASES   = 4;
	localparam int TABLE_DEPTH = 256;

	// one occurrence request, checkpoints plus the 128-base block
	typedef struct packed {
		bwt_idx_t                  pos;
		occ_cnt_t  [NUM_BASES-1:0] cnt;
		bwt_word_t [NUM_BASES-1:0] word;
	} occ_req_t;

	typedef struct packed {
		occ_cnt_t [NUM_BASES-1:0] cnt;
	} occ_result_t;

	typedef struct packed {
		bwt_idx_t x0;
		bwt_idx_t x1;
		bwt_idx_t x2;
	} bi_interval_t;

	// indexed by base code
	typedef struct packed {
		bi_interval_t [NUM_BASES-1:0] ok;
	} ext_set_t;

	typedef struct packed {
		bwt_idx_t [NUM_BASES-1:0] l2;
	} cum_cnt_t;

endpackage

/* hdl/occ_byte_lookup.sv */
// Masked byte lookup

`timescale 1ns/1ps

module occ_byte_lookup (
	input  logic                   Clk_32UI,
	input  logic                   reset_BWT_extend,
	input  logic                   stall,
	input  bwt_ext_pkg::occ_req_t  req,
	output bwt_ext_pkg::byte_cnt_t [15:0] pair_sums,
	output bwt_ext_pkg::bwt_idx_t  pos,
	output bwt_ext_pkg::occ_cnt_t  [bwt_ext_pkg::NUM_BASES-1:0] base_cnt
);

	// base counts of one byte, code c in byte c
	function automatic bwt_ext_pkg::byte_cnt_t entry_value(input logic [7:0] v);
		bwt_ext_pkg::byte_cnt_t e;
		logic [1:0]             code;
		e = '0;
		for (int f = 0; f < 4; f++) begin
			code = v[2*f +: 2];
			e[8*code +: 8] = e[8*code +: 8] + 8'd1;
		end
		return e;
	endfunction

	bwt_ext_pkg::byte_cnt_t cnt_table [bwt_ext_pkg::TABLE_DEPTH];

	// reloaded while reset is low
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int v = 0; v < bwt_ext_pkg::TABLE_DEPTH; v++) begin
				cnt_table[v] <= entry_value(8'(v));
			end
		end
	end

	// ----------------------------------------------------------------------
	// stage 1: pick and mask the half-word holding pos
	// ----------------------------------------------------------------------

	logic [31:0] sel_hw;
	logic [31:0] mask;
	logic [3:0]  pad;

	always_comb begin
		sel_hw = req.word[req.pos[6:5]][{req.pos[4], 5'b0} +: 32];
		// bases after pos are cleared and read back as A
		pad    = 4'd15 - req.pos[3:0];
		mask   = ~((32'd1 << {pad, 1'b0}) - 32'd1);
	end

	// slot 0 is the masked half-word, slots 1..7 are half-words 0..6
	logic [7:0][31:0]        hw_q;
	bwt_ext_pkg::bwt_idx_t   pos_q;
	bwt_ext_pkg::occ_cnt_t   [bwt_ext_pkg::NUM_BASES-1:0] cnt_q;

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			hw_q[0] <= sel_hw & mask;
			for (int j = 0; j < 7; j++) begin
				hw_q[j+1] <= req.word[j/2][32*(j%2) +: 32];
			end
			pos_q <= req.pos;
			cnt_q <= req.cnt;
		end
	end

	// ----------------------------------------------------------------------
	// stage 2: table lookup, bytes added in pairs
	// ----------------------------------------------------------------------

	bwt_ext_pkg::byte_cnt_t [15:0] pair_nxt;

	always_comb begin
		for (int h = 0; h < 8; h++) begin
			pair_nxt[2*h]   = cnt_table[hw_q[h][7:0]] + cnt_table[hw_q[h][15:8]];
			pair_nxt[2*h+1] = cnt_table[hw_q[h][23:16]] + cnt_table[hw_q[h][31:24]];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			pair_sums <= pair_nxt;
			pos       <= pos_q;
			base_cnt  <= cnt_q;
		end
	end

endmodule

/* hdl/occ_prefix_sum.sv */
// Occurrence prefix sum

`timescale 1ns/1ps

module occ_prefix_sum (
	input  logic                     Clk_32UI,
	input  logic                     stall,
	input  bwt_ext_pkg::byte_cnt_t   [15:0] pair_sums,
	input  bwt_ext_pkg::bwt_idx_t    pos,
	input  bwt_ext_pkg::occ_cnt_t    [bwt_ext_pkg::NUM_BASES-1:0] base_cnt,
	output bwt_ext_pkg::occ_result_t occ
);

	// position low bits and checkpoints follow the sums
	logic [6:0]            pos_d  [3:6];
	bwt_ext_pkg::occ_cnt_t [bwt_ext_pkg::NUM_BASES-1:0] base_d [3:6];

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			pos_d[3]  <= pos[6:0];
			base_d[3] <= base_cnt;
			for (int s = 4; s <= 6; s++) begin
				pos_d[s]  <= pos_d[s-1];
				base_d[s] <= base_d[s-1];
			end
		end
	end

	// ----------------------------------------------------------------------
	// stages 3 to 5: reduction into partial totals
	// ----------------------------------------------------------------------

	bwt_ext_pkg::byte_cnt_t [7:0] hw_sum;
	bwt_ext_pkg::byte_cnt_t t12, t34, t56, t78;
	bwt_ext_pkg::byte_cnt_t s1_q, s3_q, s5_q, s7_q;
	bwt_ext_pkg::byte_cnt_t p1, p12, p123, p1234;
	bwt_ext_pkg::byte_cnt_t p5, p56, p567, p5678;

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			// per half-word totals
			for (int h = 0; h < 8; h++) begin
				hw_sum[h] <= pair_sums[2*h] + pair_sums[2*h+1];
			end

			t12  <= hw_sum[0] + hw_sum[1];
			t34  <= hw_sum[2] + hw_sum[3];
			t56  <= hw_sum[4] + hw_sum[5];
			t78  <= hw_sum[6] + hw_sum[7];
			s1_q <= hw_sum[0];
			s3_q <= hw_sum[2];
			s5_q <= hw_sum[4];
			s7_q <= hw_sum[6];

			// low and high half of the block
			p1    <= s1_q;
			p12   <= t12;
			p123  <= t12 + s3_q;
			p1234 <= t12 + t34;
			p5    <= s5_q;
			p56   <= t56;
			p567  <= t56 + s7_q;
			p5678 <= t56 + t78;
		end
	end

	// ----------------------------------------------------------------------
	// stage 6: select by block, stage 7: padding and checkpoints
	// ----------------------------------------------------------------------

	bwt_ext_pkg::byte_cnt_t block_nxt;
	bwt_ext_pkg::byte_cnt_t block_q;
	bwt_ext_pkg::byte_cnt_t adj;

	always_comb begin
		case (pos_d[5][6:4])
			3'd0: block_nxt = p1;
			3'd1: block_nxt = p12;
			3'd2: block_nxt = p123;
			3'd3: block_nxt = p1234;
			3'd4: block_nxt = p1234 + p5;
			3'd5: block_nxt = p1234 + p56;
			3'd6: block_nxt = p1234 + p567;
			default: block_nxt = p1234 + p5678;
		endcase
		// masked bases were counted as A
		adj = block_q - bwt_ext_pkg::byte_cnt_t'(4'd15 - pos_d[6][3:0]);
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			block_q <= block_nxt;
			for (int c = 0; c < bwt_ext_pkg::NUM_BASES; c++) begin
				occ.cnt[c] <= base_d[6][c] + bwt_ext_pkg::occ_cnt_t'(adj[8*c +: 8]);
			end
		end
	end

endmodule

/* hdl/occ4_unit.sv */
// Occurrence count pipeline

`timescale 1ns/1ps

// counts A/C/G/T in the 128-base block up to and including pos,
// then adds the checkpoint counts

module occ4_unit (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall,
	input  bwt_ext_pkg::occ_req_t    req,
	output bwt_ext_pkg::occ_result_t occ
);

	// lookup to summing bus
	bwt_ext_pkg::byte_cnt_t [15:0] pair_sums;
	bwt_ext_pkg::occ_cnt_t  [bwt_ext_pkg::NUM_BASES-1:0] base_cnt;
	// bits 6:4 carry the block select, 3:0 the padding
	bwt_ext_pkg::bwt_idx_t         pos;

	// stages 1 and 2
	occ_byte_lookup lookup (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.req              (req),
		.pair_sums        (pair_sums),
		.pos              (pos),
		.base_cnt         (base_cnt)
	);

	// stages 3 to 7
	occ_prefix_sum summer (
		.Clk_32UI  (Clk_32UI),
		.stall     (stall),
		.pair_sums (pair_sums),
		.pos       (pos),
		.base_cnt  (base_cnt),
		.occ       (occ)
	);

endmodule

/* hdl/interval_delay.sv */
// Interval alignment delay

`timescale 1ns/1ps

module interval_delay (
	input  logic                      Clk_32UI,
	input  logic                      stall,
	input  bwt_ext_pkg::bi_interval_t ik,
	output bwt_ext_pkg::bi_interval_t ik_aligned,
	output bwt_ext_pkg::bwt_idx_t     x1_plus_x2
);

	localparam int LAST = bwt_ext_pkg::OCC_LATENCY - 1;

	// matches the occurrence pipeline depth
	bwt_ext_pkg::bi_interval_t ik_d [1:LAST];

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			ik_d[1] <= ik;
			for (int s = 2; s <= LAST; s++) begin
				ik_d[s] <= ik_d[s-1];
			end
			ik_aligned <= ik_d[LAST];
			// upper bound for the sentinel test
			x1_plus_x2 <= ik_d[LAST].x1 + ik_d[LAST].x2;
		end
	end

endmodule

/* hdl/ok_compute.sv */
// Extended interval builder

`timescale 1ns/1ps

module ok_compute (
	input  logic                      Clk_32UI,
	input  logic                      stall,
	input  bwt_ext_pkg::occ_result_t  occ_k,
	input  bwt_ext_pkg::occ_result_t  occ_l,
	input  bwt_ext_pkg::bi_interval_t ik_aligned,
	input  bwt_ext_pkg::bwt_idx_t     x1_plus_x2,
	input  bwt_ext_pkg::cum_cnt_t     cum,
	input  bwt_ext_pkg::bwt_idx_t     primary,
	input  logic [1:0]                query_base,
	output bwt_ext_pkg::ext_set_t     ok,
	output bwt_ext_pkg::bi_interval_t ok_target
);

	localparam int LAST = bwt_ext_pkg::EXT_STAGES - 1;

	// partial sets, x0 fields fill in from ok3 down
	bwt_ext_pkg::ext_set_t set_q [1:LAST];
	bwt_ext_pkg::bwt_idx_t ik_x0_q;
	logic                  sentinel_q;

	// ----------------------------------------------------------------------
	// stage 1: x1, x2 per base and the sentinel flag
	// ----------------------------------------------------------------------

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			for (int c = 0; c < bwt_ext_pkg::NUM_BASES; c++) begin
				set_q[1].ok[c].x0 <= '0;
				set_q[1].ok[c].x1 <= cum.l2[c] + bwt_ext_pkg::bwt_idx_t'(occ_k.cnt[c])
					+ 64'd1;
				set_q[1].ok[c].x2 <= bwt_ext_pkg::bwt_idx_t'(occ_l.cnt[c])
					- bwt_ext_pkg::bwt_idx_t'(occ_k.cnt[c]);
			end
			ik_x0_q <= ik_aligned.x0;
			// primary lies inside ik
			sentinel_q <= (ik_aligned.x1 <= primary) && ((x1_plus_x2 - 64'd1) >= primary);
		end
	end

	// ----------------------------------------------------------------------
	// stages 2 to 4: x0 chain
	// ----------------------------------------------------------------------

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			set_q[2] <= set_q[1];
			set_q[2].ok[3].x0 <= ik_x0_q + bwt_ext_pkg::bwt_idx_t'(sentinel_q);

			set_q[3] <= set_q[2];
			set_q[3].ok[2].x0 <= set_q[2].ok[3].x0 + set_q[2].ok[3].x2;

			set_q[4] <= set_q[3];
			set_q[4].ok[1].x0 <= set_q[3].ok[2].x0 + set_q[3].ok[2].x2;
		end
	end

	// stage 5: last link and the query select
	bwt_ext_pkg::ext_set_t set_nxt;

	always_comb begin
		set_nxt = set_q[LAST];
		set_nxt.ok[0].x0 = set_q[LAST].ok[1].x0 + set_q[LAST].ok[1].x2;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			ok <= set_nxt;
			// query 0 picks ok3, 3 picks ok0
			ok_target <= set_nxt.ok[2'd3 - query_base];
		end
	end

endmodule

/* hdl/bwt_extend.sv */
// BWT backward extension top

`timescale 1ns/1ps

module bwt_extend (
	input  logic                      Clk_32UI,
	input  logic                      reset_BWT_extend,
	input  logic                      stall,
	input  bwt_ext_pkg::occ_req_t     req_k,
	input  bwt_ext_pkg::occ_req_t     req_l,
	input  bwt_ext_pkg::bi_interval_t ik,
	input  bwt_ext_pkg::cum_cnt_t     cum,
	input  bwt_ext_pkg::bwt_idx_t     primary,
	input  logic [1:0]                query_base,
	output bwt_ext_pkg::ext_set_t     ok,
	output bwt_ext_pkg::bi_interval_t ok_target
);

	bwt_ext_pkg::occ_result_t  occ_k_res;
	bwt_ext_pkg::occ_result_t  occ_l_res;
	bwt_ext_pkg::bi_interval_t ik_aligned;
	bwt_ext_pkg::bwt_idx_t     x1_plus_x2;

	// occurrence counts up to k and up to l
	occ4_unit occ_k (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.req              (req_k),
		.occ              (occ_k_res)
	);

	occ4_unit occ_l (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.req              (req_l),
		.occ              (occ_l_res)
	);

	// ik waits for the counts
	interval_delay ik_delay (
		.Clk_32UI   (Clk_32UI),
		.stall      (stall),
		.ik         (ik),
		.ik_aligned (ik_aligned),
		.x1_plus_x2 (x1_plus_x2)
	);

	ok_compute ext (
		.Clk_32UI   (Clk_32UI),
		.stall      (stall),
		.occ_k      (occ_k_res),
		.occ_l      (occ_l_res),
		.ik_aligned (ik_aligned),
		.x1_plus_x2 (x1_plus_x2),
		.cum        (cum),
		.primary    (primary),
		.query_base (query_base),
		.ok         (ok),
		.ok_target  (ok_target)
	);

endmodule

/* tests/tb_checks.svh */
// Result compare tasks

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors   = 0;
int timeout_errors = 0;

// one interval with all three bounds
task automatic check_interval(input string name, input bwt_ext_pkg::bi_interval_t got,
		input bwt_ext_pkg::bi_interval_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("CHECK FAILED at %0t: %s got x0=%h x1=%h x2=%h, expected x0=%h x1=%h x2=%h",
			$time, name, got.x0, got.x1, got.x2, exp.x0, exp.x1, exp.x2);
	end
endtask

// all four extended intervals, reported per base code
task automatic check_set(input string name, input bwt_ext_pkg::ext_set_t got,
		input bwt_ext_pkg::ext_set_t exp);
	for (int c = 0; c < bwt_ext_pkg::NUM_BASES; c++) begin
		check_interval($sformatf("%s.ok[%0d]", name, c), got.ok[c], exp.ok[c]);
	end
endtask

`endif

/* tests/tb_bwt_extend.sv */
// BWT extension testbench

`timescale 1ns/1ps

module tb_bwt_extend;

	localparam int NUM_ITEMS      = 16;
	localparam int PIPE_DEPTH     = 12;
	localparam int RESET_CYCLES   = 4;
	localparam int RESET_TIMEOUT  = 16;
	localparam int RESULT_TIMEOUT = 64;

	logic                      Clk_32UI;
	logic                      reset_BWT_extend;
	logic                      stall;
	bwt_ext_pkg::occ_req_t     req_k;
	bwt_ext_pkg::occ_req_t     req_l;
	bwt_ext_pkg::bi_interval_t ik;
	bwt_ext_pkg::cum_cnt_t     cum;
	bwt_ext_pkg::bwt_idx_t     primary;
	logic [1:0]                query_base;
	bwt_ext_pkg::ext_set_t     ok;
	bwt_ext_pkg::bi_interval_t ok_target;

	integer seed;
	int     wait_cnt;

	// ----------------------------------------------------------------------
	// stimulus and expected values
	// ----------------------------------------------------------------------

	bwt_ext_pkg::occ_req_t     tbl_req_k  [NUM_ITEMS];
	bwt_ext_pkg::occ_req_t     tbl_req_l  [NUM_ITEMS];
	bwt_ext_pkg::bi_interval_t tbl_ik     [NUM_ITEMS];
	logic [1:0]                tbl_query  [NUM_ITEMS];
	bwt_ext_pkg::ext_set_t     tbl_ok     [NUM_ITEMS];
	bwt_ext_pkg::bi_interval_t tbl_target [NUM_ITEMS];

	// position bits 6:0 or -1 for a random value
	int k_low [NUM_ITEMS] = '{0, 15, 16, 127, 32, 48, 64, 80, 96, 112, -1, -1, -1, -1, -1, -1};
	int l_low [NUM_ITEMS] = '{127, 0, 15, 16, 47, 63, 79, 95, 111, 31, -1, -1, -1, -1, -1, -1};

	`include "tb_checks.svh"

	bwt_extend UUT (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall            (stall),
		.req_k            (req_k),
		.req_l            (req_l),
		.ik               (ik),
		.cum              (cum),
		.primary          (primary),
		.query_base       (query_base),
		.ok               (ok),
		.ok_target        (ok_target)
	);

	always #50 Clk_32UI = ~Clk_32UI;

	function automatic logic [31:0] next_random();
		logic [31:0] r;
		r = $random(seed);
		return r;
	endfunction

	// checkpoint plus matches among the first (pos mod 128) + 1 bases
	function automatic bwt_ext_pkg::occ_cnt_t model_occ(input bwt_ext_pkg::occ_req_t r,
			input int code);
		bwt_ext_pkg::occ_cnt_t total;
		int                    n;
		int                    hw;
		int                    slot;
		logic [1:0]            base;
		total = r.cnt[code];
		n     = int'(r.pos[6:0]) + 1;
		for (int i = 0; i < n; i++) begin
			hw   = i / 16;
			slot = i % 16;
			// a half-word starts at its top bit pair
			base = r.word[hw / 2][32 * (hw % 2) + 30 - 2 * slot +: 2];
			if (int'(base) == code) begin
				total = total + 32'd1;
			end
		end
		return total;
	endfunction

	function automatic bwt_ext_pkg::ext_set_t model_ext(input bwt_ext_pkg::occ_req_t rk,
			input bwt_ext_pkg::occ_req_t rl, input bwt_ext_pkg::bi_interval_t iv);
		bwt_ext_pkg::ext_set_t s;
		bwt_ext_pkg::bwt_idx_t ck;
		bwt_ext_pkg::bwt_idx_t cl;
		logic                  has_primary;
		for (int c = 0; c < bwt_ext_pkg::NUM_BASES; c++) begin
			ck         = bwt_ext_pkg::bwt_idx_t'(model_occ(rk, c));
			cl         = bwt_ext_pkg::bwt_idx_t'(model_occ(rl, c));
			s.ok[c].x1 = cum.l2[c] + ck + 64'd1;
			s.ok[c].x2 = cl - ck;
		end
		has_primary = (iv.x1 <= primary) && (iv.x1 + iv.x2 - 64'd1 >= primary);
		s.ok[3].x0  = iv.x0 + (has_primary ? 64'd1 : 64'd0);
		for (int c = 2; c >= 0; c--) begin
			s.ok[c].x0 = s.ok[c+1].x0 + s.ok[c+1].x2;
		end
		return s;
	endfunction

	task automatic build_table();
		bwt_ext_pkg::occ_req_t     rk;
		bwt_ext_pkg::occ_req_t     rl;
		bwt_ext_pkg::bi_interval_t iv;
		logic [31:0]               r;
		int                        low;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			for (int w = 0; w < bwt_ext_pkg::NUM_BASES; w++) begin
				rk.word[w] = {next_random(), next_random()};
				rl.word[w] = {next_random(), next_random()};
			end
			for (int c = 0; c < bwt_ext_pkg::NUM_BASES; c++) begin
				r          = next_random();
				rk.cnt[c]  = {8'd0, r[23:0]};
				r          = next_random();
				// l is never behind k
				rl.cnt[c]  = rk.cnt[c] + 32'd200 + {20'd0, r[11:0]};
			end
			low     = (k_low[i] < 0) ? int'(next_random() & 32'h7f) : k_low[i];
			r       = next_random();
			rk.pos  = {39'd0, r[17:0], 7'(low)};
			low     = (l_low[i] < 0) ? int'(next_random() & 32'h7f) : l_low[i];
			r       = next_random();
			rl.pos  = {39'd0, r[17:0], 7'(low)};
			r       = next_random();
			iv.x0   = {40'd0, r[23:0]};
			r       = next_random();
			// primary inside ik or at either edge, then just outside or far away
			case (i % 8)
				0: iv.x1 = primary - 64'd10;
				1: iv.x1 = primary;
				2: iv.x1 = primary - 64'd4;
				3: iv.x1 = primary - 64'd4;
				4: iv.x1 = primary + 64'd1;
				5: iv.x1 = primary + 64'd1000;
				6: iv.x1 = {44'd0, r[19:0]};
				default: iv.x1 = primary - 64'd1;
			endcase
			case (i % 8)
				0: iv.x2 = 64'd20;
				1: iv.x2 = 64'd5;
				2: iv.x2 = 64'd5;
				3: iv.x2 = 64'd4;
				4: iv.x2 = 64'd9;
				5: iv.x2 = {48'd0, r[15:0]};
				6: iv.x2 = {48'd0, r[31:16]};
				default: iv.x2 = 64'd2;
			endcase
			tbl_req_k[i]  = rk;
			tbl_req_l[i]  = rl;
			tbl_ik[i]     = iv;
			tbl_query[i]  = 2'(i % 4);
			tbl_ok[i]     = model_ext(rk, rl, iv);
			tbl_target[i] = tbl_ok[i].ok[3 - (i % 4)];
		end
	endtask

	// ----------------------------------------------------------------------
	// one pass over the table with items overlapping in the pipeline
	// ----------------------------------------------------------------------

	task automatic run_pass(input bit with_stall);
		int edges [NUM_ITEMS];
		bit live  [NUM_ITEMS];
		int next_item;
		int presented;
		int done_cnt;
		int idle;
		int ready_idx;
		int q_idx;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			edges[i] = 0;
			live[i]  = 1'b0;
		end
		next_item = 0;
		presented = -1;
		done_cnt  = 0;
		idle      = 0;
		while (done_cnt < NUM_ITEMS && idle < RESULT_TIMEOUT) begin
			@(posedge Clk_32UI);
			ready_idx = -1;
			// stall still holds the value sampled on this edge
			if (!stall) begin
				for (int i = 0; i < NUM_ITEMS; i++) begin
					if (live[i]) begin
						edges[i]++;
						if (edges[i] == PIPE_DEPTH) begin
							ready_idx = i;
							live[i]   = 1'b0;
						end
					end
				end
				if (presented >= 0) begin
					live[presented]  = 1'b1;
					edges[presented] = 1;
					presented        = -1;
				end
			end
			stall <= with_stall && ((next_random() & 32'h3) == 32'h0);
			if (presented < 0 && next_item < NUM_ITEMS) begin
				req_k     <= tbl_req_k[next_item];
				req_l     <= tbl_req_l[next_item];
				ik        <= tbl_ik[next_item];
				presented = next_item;
				next_item++;
			end
			// query for the item whose next edge writes ok
			q_idx = -1;
			for (int i = 0; i < NUM_ITEMS; i++) begin
				if (live[i] && edges[i] == PIPE_DEPTH - 1) begin
					q_idx = i;
				end
			end
			if (q_idx >= 0) begin
				query_base <= tbl_query[q_idx];
			end
			@(negedge Clk_32UI);
			if (ready_idx >= 0) begin
				check_set($sformatf("ok (item %0d)", ready_idx), ok, tbl_ok[ready_idx]);
				check_interval($sformatf("ok_target (item %0d)", ready_idx), ok_target,
					tbl_target[ready_idx]);
				done_cnt++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (done_cnt < NUM_ITEMS) begin
			timeout_errors++;
			$display("ERROR: timeout, only %0d of %0d results arrived (stall run %0d)",
				done_cnt, NUM_ITEMS, with_stall);
		end
	endtask

	initial begin
		seed             = 32'h4a18_d79e;
		Clk_32UI         = 1'b0;
		reset_BWT_extend = 1'b0;
		stall            = 1'b0;
		req_k            = '0;
		req_l            = '0;
		ik               = '0;
		query_base       = 2'd0;
		primary          = 64'h0000_0000_00a5_c3e1;
		cum.l2[0]        = 64'd0;
		cum.l2[1]        = 64'h0000_0000_0130_2a11;
		cum.l2[2]        = 64'h0000_0000_025e_7c04;
		cum.l2[3]        = 64'h0000_0000_0391_b5f3;
		build_table();

		// table loads while reset is low
		repeat (RESET_CYCLES) @(posedge Clk_32UI);
		reset_BWT_extend <= 1'b1;
		wait_cnt = 0;
		while (reset_BWT_extend !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
			@(negedge Clk_32UI);
			wait_cnt++;
		end
		if (reset_BWT_extend !== 1'b1) begin
			timeout_errors++;
			$display("ERROR: timeout, reset was never released");
		end

		run_pass(1'b0);
		run_pass(1'b1);

		$display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+tests
hdl/bwt_ext_pkg.sv
hdl/occ_byte_lookup.sv
hdl/occ_prefix_sum.sv
hdl/occ4_unit.sv
hdl/interval_delay.sv
hdl/ok_compute.sv
hdl/bwt_extend.sv
tests/tb_bwt_extend.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the BWT extension testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_bwt_extend -f tb.f -o sim_bwt_extend

./obj_dir/sim_bwt_extend > sim.log 2>&1
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
